/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  // stall/flush vectors carry one bit per stage
  // 0 pc, 1 if/id, 2 id/ex, 3 ex/mem, 4 mem/wb, 5 wb
  localparam int STAGE_W     = 6;
  localparam int N_PIPE_REGS = 5; // valid regs behind the pc
  localparam int REG_ADDR_W  = 5;

  localparam int STG_PC   = 0;
  localparam int STG_IFID = 1; // first valid register
  localparam int STG_WB   = 5; // last one, retires

  // mul/div occupancy, counted from the start pulse
  localparam int MULDIV_CYCLES = 4;
  localparam int MD_CNT_W      = $clog2(MULDIV_CYCLES);

  localparam logic [MD_CNT_W-1:0] MD_CNT_INIT = MD_CNT_W'(MULDIV_CYCLES - 1);
  localparam logic [MD_CNT_W-1:0] MD_CNT_LAST = MD_CNT_W'(1); // final busy cycle

  // load-use: hold pc and if/id, bubble into id/ex
  localparam logic [STAGE_W-1:0] STALL_LOAD_USE   = 6'b000011;
  localparam logic [STAGE_W-1:0] FLUSH_LOAD_USE   = 6'b000100;

  // taken jump in ex kills if/id and id/ex
  localparam logic [STAGE_W-1:0] STALL_JUMP       = 6'b000010;
  localparam logic [STAGE_W-1:0] FLUSH_JUMP       = 6'b000110;

  localparam logic [STAGE_W-1:0] STALL_MULDIV     = 6'b000111;
  localparam logic [STAGE_W-1:0] FLUSH_MULDIV     = 6'b001000;

  // csr trap freezes everything
  localparam logic [STAGE_W-1:0] STALL_TRAP_CSR   = 6'b111111;
  localparam logic [STAGE_W-1:0] FLUSH_TRAP_CSR   = 6'b001110;

  localparam logic [STAGE_W-1:0] STALL_TRAP_ECALL = 6'b000010;
  localparam logic [STAGE_W-1:0] FLUSH_TRAP_ECALL = 6'b001110;

  // data side memory busy, bubble into mem/wb
  localparam logic [STAGE_W-1:0] STALL_RAM_MEM    = 6'b000111;
  localparam logic [STAGE_W-1:0] FLUSH_RAM_MEM    = 6'b010000;

  // fetch side busy only needs pc and if/id held
  localparam logic [STAGE_W-1:0] STALL_RAM_IF     = 6'b000011;
  localparam logic [STAGE_W-1:0] FLUSH_RAM_IF     = 6'b000000;

  localparam logic [STAGE_W-1:0] STALL_RESET      = 6'b000000;
  localparam logic [STAGE_W-1:0] FLUSH_RESET      = 6'b011111;

  // winning hazard cause, highest priority first
  typedef enum logic [3:0] {
    HZ_RESET,
    HZ_ARB_PASS,   // both rams busy but arbiter has the write data
    HZ_RAM_MEM,
    HZ_RAM_IF,
    HZ_TRAP_FLUSH,
    HZ_TRAP_STALL,
    HZ_JUMP,
    HZ_MULDIV,
    HZ_LOAD_USE,
    HZ_NONE
  } hazard_e;

  // mul/div sequencer
  typedef enum logic {
    MD_IDLE,
    MD_BUSY
  } md_state_e;

endpackage

`default_nettype wire

/* compile.f */
+incdir+tb
common/pipe_pkg.sv
hazard_unit/hazard_detect.sv
hazard_unit/pipeline_control.sv
hdl/stage_valid_chain.sv
hdl/pipe_ctrl_top.sv
tb/tb_pipe_ctrl.sv

/* hazard_unit/hazard_detect.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_detect (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_rs1_i,
  input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_rs2_i,
  input  wire logic [pipe_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  wire logic                            ex_is_load_i,
  input  wire logic                            ex_muldiv_start_i,
  input  wire logic                            ram_if_busy_i,
  input  wire logic                            ram_mem_busy_i,
  input  wire logic                            arb_wdata_ready_i,
  input  wire logic                            trap_stall_i,
  input  wire logic                            trap_flush_i,
  input  wire logic                            jump_taken_i,
  output logic                                 load_use_req_o,
  output logic                                 muldiv_req_o,
  output logic                                 ram_if_req_o,
  output logic                                 ram_mem_req_o,
  output logic                                 arb_ready_o,
  output logic                                 trap_stall_req_o,
  output logic                                 trap_flush_req_o,
  output logic                                 jump_req_o
);

  pipe_pkg::md_state_e             md_state_q;
  logic [pipe_pkg::MD_CNT_W-1:0]   md_cnt_q;   // busy cycles still to go
  logic                            md_start;

  // load in ex writing a reg that id reads, x0 never hazards
  assign load_use_req_o = ex_is_load_i && (ex_rd_i != '0) &&
                          ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

  // start only taken while idle
  assign md_start = ex_muldiv_start_i && (md_state_q == pipe_pkg::MD_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      md_state_q <= pipe_pkg::MD_IDLE;
      md_cnt_q   <= '0;
    end else begin
      case (md_state_q)
        pipe_pkg::MD_IDLE: begin
          if (md_start) begin
            md_state_q <= pipe_pkg::MD_BUSY;
            md_cnt_q   <= pipe_pkg::MD_CNT_INIT;
          end
        end
        pipe_pkg::MD_BUSY: begin
          md_cnt_q <= md_cnt_q - 1'b1;
          if (md_cnt_q == pipe_pkg::MD_CNT_LAST) begin
            md_state_q <= pipe_pkg::MD_IDLE;
          end
        end
        default: begin
          md_state_q <= pipe_pkg::MD_IDLE;
          md_cnt_q   <= '0;
        end
      endcase
    end
  end

  // start cycle counts as the first one
  assign muldiv_req_o = md_start || (md_state_q == pipe_pkg::MD_BUSY);

  // remaining sources go straight to the decoder
  assign ram_if_req_o     = ram_if_busy_i;
  assign ram_mem_req_o    = ram_mem_busy_i;
  assign arb_ready_o      = arb_wdata_ready_i;
  assign trap_stall_req_o = trap_stall_i;
  assign trap_flush_req_o = trap_flush_i;
  assign jump_req_o       = jump_taken_i;

  a_md_cnt_range: assert property (@(posedge clk) disable iff (rst)
    (md_state_q == pipe_pkg::MD_BUSY) |->
      (md_cnt_q != '0) && (md_cnt_q <= pipe_pkg::MULDIV_CYCLES - 1))
    else $error("mul/div counter out of range: %0d", md_cnt_q);

  // an accepted start keeps the request up for the full latency
  a_md_len: assert property (@(posedge clk) disable iff (rst)
    md_start |-> muldiv_req_o [*pipe_pkg::MULDIV_CYCLES])
    else $error("mul/div request dropped early");

endmodule

`default_nettype wire

/* hazard_unit/pipeline_control.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeline_control (
  input  wire logic                         rst,
  input  wire logic                         load_use_req_i,
  input  wire logic                         muldiv_req_i,
  input  wire logic                         ram_if_req_i,
  input  wire logic                         ram_mem_req_i,
  input  wire logic                         arb_ready_i,
  input  wire logic                         trap_stall_req_i,
  input  wire logic                         trap_flush_req_i,
  input  wire logic                         jump_req_i,
  output logic [pipe_pkg::STAGE_W-1:0]      stall_o,
  output logic [pipe_pkg::STAGE_W-1:0]      flush_o
);

  pipe_pkg::hazard_e cause;

  // later stage wins, reset above all
  always_comb begin
    if (rst) begin
      cause = pipe_pkg::HZ_RESET;
    end else if (ram_if_req_i && ram_mem_req_i && arb_ready_i) begin
      cause = pipe_pkg::HZ_ARB_PASS;
    end else if (ram_mem_req_i) begin
      cause = pipe_pkg::HZ_RAM_MEM;
    end else if (ram_if_req_i) begin
      cause = pipe_pkg::HZ_RAM_IF;
    end else if (trap_flush_req_i) begin
      cause = pipe_pkg::HZ_TRAP_FLUSH;
    end else if (trap_stall_req_i) begin
      cause = pipe_pkg::HZ_TRAP_STALL;
    end else if (jump_req_i) begin
      cause = pipe_pkg::HZ_JUMP;
    end else if (muldiv_req_i) begin
      cause = pipe_pkg::HZ_MULDIV;
    end else if (load_use_req_i) begin
      cause = pipe_pkg::HZ_LOAD_USE;
    end else begin
      cause = pipe_pkg::HZ_NONE;
    end
  end

  always_comb begin
    case (cause)
      pipe_pkg::HZ_RESET: begin
        stall_o = pipe_pkg::STALL_RESET;
        flush_o = pipe_pkg::FLUSH_RESET;
      end
      pipe_pkg::HZ_RAM_MEM: begin
        stall_o = pipe_pkg::STALL_RAM_MEM;
        flush_o = pipe_pkg::FLUSH_RAM_MEM;
      end
      pipe_pkg::HZ_RAM_IF: begin
        stall_o = pipe_pkg::STALL_RAM_IF;
        flush_o = pipe_pkg::FLUSH_RAM_IF;
      end
      pipe_pkg::HZ_TRAP_FLUSH: begin // ecall style, no full freeze
        stall_o = pipe_pkg::STALL_TRAP_ECALL;
        flush_o = pipe_pkg::FLUSH_TRAP_ECALL;
      end
      pipe_pkg::HZ_TRAP_STALL: begin
        stall_o = pipe_pkg::STALL_TRAP_CSR;
        flush_o = pipe_pkg::FLUSH_TRAP_CSR;
      end
      pipe_pkg::HZ_JUMP: begin
        stall_o = pipe_pkg::STALL_JUMP;
        flush_o = pipe_pkg::FLUSH_JUMP;
      end
      pipe_pkg::HZ_MULDIV: begin
        stall_o = pipe_pkg::STALL_MULDIV;
        flush_o = pipe_pkg::FLUSH_MULDIV;
      end
      pipe_pkg::HZ_LOAD_USE: begin
        stall_o = pipe_pkg::STALL_LOAD_USE;
        flush_o = pipe_pkg::FLUSH_LOAD_USE;
      end
      default: begin // arb pass and no hazard
        stall_o = '0;
        flush_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/pipe_ctrl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_rs1_i,
  input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_rs2_i,
  input  wire logic [pipe_pkg::REG_ADDR_W-1:0] ex_rd_i,
  input  wire logic                            ex_is_load_i,
  input  wire logic                            ex_muldiv_start_i,
  input  wire logic                            ram_if_busy_i,
  input  wire logic                            ram_mem_busy_i,
  input  wire logic                            arb_wdata_ready_i,
  input  wire logic                            trap_stall_i,
  input  wire logic                            trap_flush_i,
  input  wire logic                            jump_taken_i,
  input  wire logic                            fetch_valid_i,
  output logic [pipe_pkg::STAGE_W-1:0]         stall_o,
  output logic [pipe_pkg::STAGE_W-1:0]         flush_o,
  output logic                                 fetch_ready_o,
  output logic [pipe_pkg::N_PIPE_REGS-1:0]     stage_valid_o,
  output logic                                 retire_o
);

  // hazard requests into the decoder
  logic load_use_req;
  logic muldiv_req;
  logic ram_if_req;
  logic ram_mem_req;
  logic arb_ready;
  logic trap_stall_req;
  logic trap_flush_req;
  logic jump_req;

  hazard_detect i_hazard_detect (
    .clk               (clk),
    .rst               (rst),
    .id_rs1_i          (id_rs1_i),
    .id_rs2_i          (id_rs2_i),
    .ex_rd_i           (ex_rd_i),
    .ex_is_load_i      (ex_is_load_i),
    .ex_muldiv_start_i (ex_muldiv_start_i),
    .ram_if_busy_i     (ram_if_busy_i),
    .ram_mem_busy_i    (ram_mem_busy_i),
    .arb_wdata_ready_i (arb_wdata_ready_i),
    .trap_stall_i      (trap_stall_i),
    .trap_flush_i      (trap_flush_i),
    .jump_taken_i      (jump_taken_i),
    .load_use_req_o    (load_use_req),
    .muldiv_req_o      (muldiv_req),
    .ram_if_req_o      (ram_if_req),
    .ram_mem_req_o     (ram_mem_req),
    .arb_ready_o       (arb_ready),
    .trap_stall_req_o  (trap_stall_req),
    .trap_flush_req_o  (trap_flush_req),
    .jump_req_o        (jump_req)
  );

  pipeline_control i_pipeline_control (
    .rst              (rst),
    .load_use_req_i   (load_use_req),
    .muldiv_req_i     (muldiv_req),
    .ram_if_req_i     (ram_if_req),
    .ram_mem_req_i    (ram_mem_req),
    .arb_ready_i      (arb_ready),
    .trap_stall_req_i (trap_stall_req),
    .trap_flush_req_i (trap_flush_req),
    .jump_req_i       (jump_req),
    .stall_o          (stall_o),
    .flush_o          (flush_o)
  );

  // chain sees the same vectors that leave the block
  stage_valid_chain i_stage_valid_chain (
    .clk           (clk),
    .rst           (rst),
    .stall_i       (stall_o),
    .flush_i       (flush_o),
    .fetch_valid_i (fetch_valid_i),
    .fetch_ready_o (fetch_ready_o),
    .stage_valid_o (stage_valid_o),
    .retire_o      (retire_o)
  );

endmodule

`default_nettype wire

/* hdl/stage_valid_chain.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_valid_chain (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic [pipe_pkg::STAGE_W-1:0]  stall_i,
  input  wire logic [pipe_pkg::STAGE_W-1:0]  flush_i,
  input  wire logic                          fetch_valid_i,
  output logic                               fetch_ready_o,
  output logic [pipe_pkg::N_PIPE_REGS-1:0]   stage_valid_o,
  output logic                               retire_o
);

  // valid_q[k-1] belongs to stage bit k
  logic [pipe_pkg::N_PIPE_REGS-1:0] valid_q;
  logic [pipe_pkg::N_PIPE_REGS-1:0] valid_src; // value each reg takes on advance
  logic                             fetch_take;

  // fetch is blocked whenever the pc is held
  assign fetch_ready_o = ~stall_i[pipe_pkg::STG_PC];
  assign fetch_take    = fetch_valid_i & fetch_ready_o;

  assign valid_src = {valid_q[pipe_pkg::N_PIPE_REGS-2:0], fetch_take};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      for (int k = pipe_pkg::STG_IFID; k <= pipe_pkg::STG_WB; k++) begin
        if (flush_i[k]) begin
          valid_q[k-1] <= 1'b0;           // flush beats stall
        end else if (!stall_i[k]) begin
          valid_q[k-1] <= valid_src[k-1];
        end
        // stalled regs keep their token
      end
    end
  end

  assign stage_valid_o = valid_q;

  // wb token leaves only if wb itself is not held
  assign retire_o = valid_q[pipe_pkg::STG_WB-1] & ~stall_i[pipe_pkg::STG_WB];

  a_no_retire_rst: assert property (@(posedge clk)
    rst |=> !retire_o)
    else $error("retire seen right after reset");

  // pc hold must also hold or kill if/id, otherwise a fetch slot is lost
  a_pc_hold: assert property (@(posedge clk) disable iff (rst)
    stall_i[pipe_pkg::STG_PC] |->
      (stall_i[pipe_pkg::STG_IFID] || flush_i[pipe_pkg::STG_IFID]))
    else $error("pc stalled while if/id advances");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

TOP=tb_pipe_ctrl
LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir obj_dir -f compile.f > "$LOG" 2>&1 \
  && ./obj_dir/V"$TOP" >> "$LOG" 2>&1 \
  || echo "build or simulation exited with an error" >> "$LOG"

tail -n 5 "$LOG"

grep -qx "Everything OK" "$LOG" \
  && echo "PASS" \
  || { echo "FAIL, see $LOG"; exit 1; }

/* tb/tb_pipe_ref.svh */
`ifndef TB_PIPE_REF_SVH
`define TB_PIPE_REF_SVH

// only a load with a real destination can collide with the id sources
function automatic logic ref_load_use(input logic                            is_load,
                                      input logic [pipe_pkg::REG_ADDR_W-1:0] rd,
                                      input logic [pipe_pkg::REG_ADDR_W-1:0] rs1,
                                      input logic [pipe_pkg::REG_ADDR_W-1:0] rs2);
  if (!is_load || rd == '0) begin
    return 1'b0;
  end
  return (rd == rs1) || (rd == rs2);
endfunction

// fixed priority, later stages are tested first
function automatic pipe_pkg::hazard_e ref_decode(
  input  logic                         in_rst,
  input  logic                         in_ram_if,
  input  logic                         in_ram_mem,
  input  logic                         in_arb,
  input  logic                         in_trap_flush,
  input  logic                         in_trap_stall,
  input  logic                         in_jump,
  input  logic                         in_muldiv,
  input  logic                         in_load_use,
  output logic [pipe_pkg::STAGE_W-1:0] stall_v,
  output logic [pipe_pkg::STAGE_W-1:0] flush_v
);
  pipe_pkg::hazard_e              cause;
  logic [2*pipe_pkg::STAGE_W-1:0] pair; // stall in the upper half
  if (in_rst) cause = pipe_pkg::HZ_RESET;
  else if (in_ram_if && in_ram_mem && in_arb) cause = pipe_pkg::HZ_ARB_PASS;
  else if (in_ram_mem) cause = pipe_pkg::HZ_RAM_MEM;
  else if (in_ram_if) cause = pipe_pkg::HZ_RAM_IF;
  else if (in_trap_flush) cause = pipe_pkg::HZ_TRAP_FLUSH;
  else if (in_trap_stall) cause = pipe_pkg::HZ_TRAP_STALL;
  else if (in_jump) cause = pipe_pkg::HZ_JUMP;
  else if (in_muldiv) cause = pipe_pkg::HZ_MULDIV;
  else if (in_load_use) cause = pipe_pkg::HZ_LOAD_USE;
  else cause = pipe_pkg::HZ_NONE;
  case (cause)
    pipe_pkg::HZ_RESET:      pair = {pipe_pkg::STALL_RESET, pipe_pkg::FLUSH_RESET};
    pipe_pkg::HZ_RAM_MEM:    pair = {pipe_pkg::STALL_RAM_MEM, pipe_pkg::FLUSH_RAM_MEM};
    pipe_pkg::HZ_RAM_IF:     pair = {pipe_pkg::STALL_RAM_IF, pipe_pkg::FLUSH_RAM_IF};
    pipe_pkg::HZ_TRAP_FLUSH: pair = {pipe_pkg::STALL_TRAP_ECALL, pipe_pkg::FLUSH_TRAP_ECALL};
    pipe_pkg::HZ_TRAP_STALL: pair = {pipe_pkg::STALL_TRAP_CSR, pipe_pkg::FLUSH_TRAP_CSR};
    pipe_pkg::HZ_JUMP:       pair = {pipe_pkg::STALL_JUMP, pipe_pkg::FLUSH_JUMP};
    pipe_pkg::HZ_MULDIV:     pair = {pipe_pkg::STALL_MULDIV, pipe_pkg::FLUSH_MULDIV};
    pipe_pkg::HZ_LOAD_USE:   pair = {pipe_pkg::STALL_LOAD_USE, pipe_pkg::FLUSH_LOAD_USE};
    default:                 pair = '0; // arbiter pass and idle
  endcase
  stall_v = pair[2*pipe_pkg::STAGE_W-1:pipe_pkg::STAGE_W];
  flush_v = pair[pipe_pkg::STAGE_W-1:0];
  return cause;
endfunction

// one edge of the valid chain
function automatic logic [pipe_pkg::N_PIPE_REGS-1:0] ref_chain_next(
  input logic [pipe_pkg::N_PIPE_REGS-1:0] valid,
  input logic [pipe_pkg::STAGE_W-1:0]     stall_v,
  input logic [pipe_pkg::STAGE_W-1:0]     flush_v,
  input logic                             fetch_v
);
  logic [pipe_pkg::N_PIPE_REGS:0]   src;
  logic [pipe_pkg::N_PIPE_REGS-1:0] nxt;
  src = {valid, fetch_v & ~stall_v[0]}; // src[k-1] feeds stage bit k
  for (int k = 1; k <= pipe_pkg::N_PIPE_REGS; k++) begin
    if (flush_v[k]) nxt[k-1] = 1'b0;
    else if (stall_v[k]) nxt[k-1] = valid[k-1];
    else nxt[k-1] = src[k-1];
  end
  return nxt;
endfunction

`endif

/* tb/tb_pipe_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_ctrl;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 10;
  localparam int DIRECTED_CYCLES = 200;
  localparam int RANDOM_CYCLES   = 2000;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 790;
  localparam int REG_W           = pipe_pkg::REG_ADDR_W;
  localparam logic [31:0] RAND_SEED = 32'h4bee;

  logic                             clk = 1'b0;
  logic                             rst;
  logic [REG_W-1:0]                 id_rs1_i;
  logic [REG_W-1:0]                 id_rs2_i;
  logic [REG_W-1:0]                 ex_rd_i;
  logic                             ex_is_load_i;
  logic                             ex_muldiv_start_i;
  logic                             ram_if_busy_i;
  logic                             ram_mem_busy_i;
  logic                             arb_wdata_ready_i;
  logic                             trap_stall_i;
  logic                             trap_flush_i;
  logic                             jump_taken_i;
  logic                             fetch_valid_i;
  logic [pipe_pkg::STAGE_W-1:0]     stall_o;
  logic [pipe_pkg::STAGE_W-1:0]     flush_o;
  logic                             fetch_ready_o;
  logic [pipe_pkg::N_PIPE_REGS-1:0] stage_valid_o;
  logic                             retire_o;

  int err_cnt   = 0;
  int check_cnt = 0;
  int cycle_cnt = 0;

  // expected register state, one edge ahead of the compare
  logic [pipe_pkg::N_PIPE_REGS-1:0] model_valid   = '0;
  int                               model_md_left = 0; // mul/div busy cycles left
  logic                             model_known   = 1'b0;

  `include "tb_pipe_ref.svh"

  pipe_ctrl_top i_dut (.*);

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_vec(input string name, input logic [pipe_pkg::STAGE_W-1:0] exp_v,
                           input logic [pipe_pkg::STAGE_W-1:0] act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("[ERROR] %s expected 0x%0h got 0x%0h (cycle %0d)", name, exp_v, act_v, cycle_cnt);
    end
  endtask

  task automatic check_valid(input string name, input logic [pipe_pkg::N_PIPE_REGS-1:0] exp_v,
                             input logic [pipe_pkg::N_PIPE_REGS-1:0] act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("[ERROR] %s expected 0x%0h got 0x%0h (cycle %0d)", name, exp_v, act_v, cycle_cnt);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("[ERROR] %s expected 0x%0h got 0x%0h (cycle %0d)", name, exp_v, act_v, cycle_cnt);
    end
  endtask

  task automatic drive_idle();
    {ram_if_busy_i, ram_mem_busy_i, arb_wdata_ready_i} <= '0;
    {trap_stall_i, trap_flush_i, jump_taken_i} <= '0;
    {ex_is_load_i, ex_muldiv_start_i, fetch_valid_i} <= '0;
    {ex_rd_i, id_rs1_i, id_rs2_i} <= '0;
  endtask

  // req is {ram_if, ram_mem, arb, trap_stall, trap_flush, jump}, regs is {rd, rs1, rs2}
  task automatic apply_case(input logic [5:0] req, input logic is_load,
                            input logic [3*REG_W-1:0] regs);
    @(posedge clk);
    drive_idle();
    {ram_if_busy_i, ram_mem_busy_i, arb_wdata_ready_i} <= req[5:3];
    {trap_stall_i, trap_flush_i, jump_taken_i} <= req[2:0];
    ex_is_load_i <= is_load;
    {ex_rd_i, id_rs1_i, id_rs2_i} <= regs;
    @(posedge clk);
    drive_idle();
  endtask

  // second start lands while busy and must not extend the run
  task automatic run_muldiv_burst();
    int busy_cycles;
    busy_cycles = 0;
    for (int i = 0; i < 2 * pipe_pkg::MULDIV_CYCLES; i++) begin
      @(posedge clk);
      ex_muldiv_start_i <= (i == 0 || i == 2);
      @(negedge clk);
      if (stall_o == pipe_pkg::STALL_MULDIV && flush_o == pipe_pkg::FLUSH_MULDIV) busy_cycles++;
    end
    check_cnt++;
    if (busy_cycles != pipe_pkg::MULDIV_CYCLES) begin
      err_cnt++;
      $display("[ERROR] muldiv run length expected 0x%0h got 0x%0h",
               pipe_pkg::MULDIV_CYCLES, busy_cycles);
    end
  endtask

  // lone token, counted from its fetch cycle to retire
  task automatic check_token_latency();
    int lat;
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    lat = 1;
    @(negedge clk);
    while (retire_o !== 1'b1 && lat < 4 * pipe_pkg::N_PIPE_REGS) begin
      @(negedge clk);
      lat++;
    end
    check_cnt++;
    if (lat != pipe_pkg::N_PIPE_REGS) begin
      err_cnt++;
      $display("[ERROR] retire latency expected 0x%0h got 0x%0h", pipe_pkg::N_PIPE_REGS, lat);
    end
  endtask

  task automatic run_random(input int n_cycles);
    for (int i = 0; i < n_cycles; i++) begin
      @(posedge clk);
      ram_if_busy_i     <= ($urandom_range(7, 0) == 0);
      ram_mem_busy_i    <= ($urandom_range(7, 0) == 0);
      arb_wdata_ready_i <= ($urandom_range(3, 0) == 0);
      trap_stall_i      <= ($urandom_range(15, 0) == 0);
      trap_flush_i      <= ($urandom_range(15, 0) == 0);
      jump_taken_i      <= ($urandom_range(7, 0) == 0);
      ex_muldiv_start_i <= ($urandom_range(9, 0) == 0);
      ex_is_load_i      <= ($urandom_range(1, 0) == 0);
      ex_rd_i           <= REG_W'($urandom_range(3, 0)); // narrow range, frequent matches
      id_rs1_i          <= REG_W'($urandom_range(3, 0));
      id_rs2_i          <= REG_W'($urandom_range(3, 0));
      fetch_valid_i     <= ($urandom_range(3, 0) != 0);
    end
  endtask

  // inputs change only at the rising edge, so everything is settled here
  always @(negedge clk) begin : compare_outputs
    logic                         md_take;
    logic [pipe_pkg::STAGE_W-1:0] exp_stall;
    logic [pipe_pkg::STAGE_W-1:0] exp_flush;
    md_take = ex_muldiv_start_i && (model_md_left == 0);
    void'(ref_decode(rst, ram_if_busy_i, ram_mem_busy_i, arb_wdata_ready_i, trap_flush_i,
                     trap_stall_i, jump_taken_i, md_take || (model_md_left > 0),
                     ref_load_use(ex_is_load_i, ex_rd_i, id_rs1_i, id_rs2_i),
                     exp_stall, exp_flush));
    check_vec("stall_o", exp_stall, stall_o);
    check_vec("flush_o", exp_flush, flush_o);
    check_bit("fetch_ready_o", ~exp_stall[pipe_pkg::STG_PC], fetch_ready_o);
    if (model_known) begin
      check_valid("stage_valid_o", model_valid, stage_valid_o);
      check_bit("retire_o", model_valid[pipe_pkg::N_PIPE_REGS-1] & ~exp_stall[pipe_pkg::STG_WB],
                retire_o);
    end
    if (rst) begin
      model_valid   = '0;
      model_md_left = 0;
      model_known   = 1'b1;
    end else begin
      model_valid = ref_chain_next(model_valid, exp_stall, exp_flush, fetch_valid_i);
      if (md_take) model_md_left = pipe_pkg::MULDIV_CYCLES - 1;
      else if (model_md_left > 0) model_md_left--;
    end
  end

  initial begin : watchdog
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: run still going after %0d cycles", cycle_cnt);
    $display("Something failed");
    $finish;
  end

  initial begin : stimulus
    int seed_val;
    seed_val = $urandom(RAND_SEED);
    rst = 1'b1;
    {ram_if_busy_i, ram_mem_busy_i, arb_wdata_ready_i} = '0;
    {trap_stall_i, trap_flush_i, jump_taken_i} = '0;
    {ex_is_load_i, ex_muldiv_start_i, fetch_valid_i} = '0;
    {ex_rd_i, id_rs1_i, id_rs2_i} = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 6; i++) begin
      apply_case(6'b100000 >> i, 1'b0, '0);
    end
    apply_case(6'b111000, 1'b0, '0); // arbiter pass, no stall at all
    apply_case(6'b110000, 1'b0, '0);
    apply_case(6'b011111, 1'b0, '0);
    apply_case('0, 1'b1, {5'd5, 5'd5, 5'd0});
    apply_case('0, 1'b1, {5'd7, 5'd0, 5'd7});
    apply_case('0, 1'b1, {5'd0, 5'd0, 5'd0}); // x0 never hazards
    apply_case('0, 1'b1, {5'd3, 5'd4, 5'd6});
    apply_case('0, 1'b0, {5'd9, 5'd9, 5'd9});
    run_muldiv_burst();
    check_token_latency();
    run_random(RANDOM_CYCLES);
    @(posedge clk);
    drive_idle();
    repeat (2) @(negedge clk);
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
